//--- compile.f
+incdir+src
src/core_mem_pkg.sv
src/l15_pkg.sv
src/mem_addr_gen.sv
src/l15_req_fsm.sv
src/load_extend.sv
src/mem_stage.sv
dv/tb_mem_stage.sv

//--- Makefile
# Verilator build and run of the memory stage testbench

VERILATOR  ?= verilator
TOP        := tb_mem_stage
FILELIST   := compile.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND

SIM_BIN    := $(BUILD_DIR)/V$(TOP)
SRCS       := $(shell grep -v '^+' $(FILELIST)) src/mem_params.svh

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	    echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_mem_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory stage: clock and reset, LFSR random loads and
// stores, L1.5 responder with a reference byte memory, checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mem_params.svh"

module tb_mem_stage
    import core_mem_pkg::*, l15_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_OPS    = 300;
    localparam int    WAIT_LIMIT = 200;
    localparam addr_t MEM_BASE   = 32'h0000_2000;
    localparam int    SEL_REQ    = 0;
    localparam int    SEL_DONE   = 1;
    localparam int    SEL_LD_MIS = 2;
    localparam int    SEL_ST_MIS = 3;
    // lb lbu lh lhu lw sb sh sw
    localparam mem_op_t OPS [8] = '{4'b0101, 4'b0100, 4'b0011, 4'b0010, 4'b0111,
                                    4'b1100, 4'b1010, 4'b1110};

    logic         clk = 1'b0;
    logic         nrst;
    mem_op_t      mem_op;
    word_t        op_a;
    word_t        op_b;
    word_t        s_imm;
    l15_req_t     l15_req;
    logic         l15_req_val;
    l15_resp_t    l15_resp;
    logic         l15_resp_val;
    logic         l15_ack;
    logic         l15_header_ack;
    logic         l15_resp_ack;
    word_t        load_data;
    logic         busy;
    logic         done;
    logic         ld_misaligned;
    logic         st_misaligned;

    logic [7:0]   ref_mem [128];     // cache model with byte 0 at MEM_BASE
    logic [31:0]  lfsr = 32'd86565;
    int           errors = 0;
    int           n_ops = 0;
    int           n_mis = 0;
    int           n_inject = 0;
    logic         timed_out = 1'b0;

    mem_stage i_dut (.*);

    always #4 clk = ~clk;

    // one LFSR step per bit taken with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t reverse_bytes(input word_t w);
        word_t r;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            r = {r[23:0], w[7:0]};
            w = w >> 8;
        end
        return r;
    endfunction

    function automatic int width_bytes(input mem_op_t op);
        case (op[2:1])
            2'b10:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic l15_size_t msg_size(input int nb);
        if (nb == 1) return `MSG_SIZE_1B;
        if (nb == 2) return `MSG_SIZE_2B;
        return `MSG_SIZE_4B;
    endfunction

    // whole 16-byte line with byte 0 on top of data_0
    function automatic l15_resp_t line_resp(input addr_t addr, input l15_rettype_t rt);
        l15_resp_t r;
        int        base;
        base         = int'(addr - MEM_BASE) & ~15;
        r.returntype = rt;
        r.data_0     = '0;
        r.data_1     = '0;
        for (int k = 0; k < 8; k++) begin
            r.data_0 = {r.data_0[55:0], ref_mem[7'(base + k)]};
            r.data_1 = {r.data_1[55:0], ref_mem[7'(base + 8 + k)]};
        end
        return r;
    endfunction

    function automatic word_t expect_load(input mem_op_t op, input addr_t addr);
        word_t v;
        int    nb;
        int    idx;
        nb  = width_bytes(op);
        idx = int'(addr - MEM_BASE);
        v   = '0;
        for (int i = nb - 1; i >= 0; i--) begin
            v = {v[23:0], ref_mem[7'(idx + i)]};
        end
        if (op[0] && nb == 1 && v[7]) v[31:8] = '1;
        if (op[0] && nb == 2 && v[15]) v[31:16] = '1;
        return v;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            SEL_REQ:    return l15_req_val;
            SEL_DONE:   return done;
            SEL_LD_MIS: return ld_misaligned;
            default:    return st_misaligned;
        endcase
    endfunction

    task automatic value_error(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic event_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("ops %0d, misaligned %0d, unmatched returns %0d, errors %0d",
                 n_ops, n_mis, n_inject, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic wait_for(input int sel, input string what, output int n);
        n = 0;
        while (!watched(sel) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!watched(sel)) begin
            $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic step_busy();
        @(negedge clk);
        if (!busy) event_error("busy low before done");
    endtask

    task automatic check_idle(input string when);
        if (l15_req_val || l15_resp_ack || done || busy || ld_misaligned || st_misaligned)
            value_error($sformatf("%s: req_val %b resp_ack %b done %b busy %b mis %b%b",
                when, l15_req_val, l15_resp_ack, done, busy, ld_misaligned, st_misaligned));
    endtask

    // responder writes the lanes of size and offset with bytes of the reversed data
    task automatic apply_store(input l15_req_t req);
        word_t rev;
        word_t sh;
        int    nb;
        int    off;
        int    wbase;
        rev   = reverse_bytes(req.data);
        nb    = (req.size == `MSG_SIZE_1B) ? 1 : (req.size == `MSG_SIZE_2B) ? 2 : 4;
        off   = int'(req.address[1:0]);
        wbase = int'(req.address - MEM_BASE) & ~3;
        for (int lane = off; lane < off + nb; lane++) begin
            sh = rev >> (8 * lane);
            ref_mem[7'(wbase + lane)] = sh[7:0];
        end
    endtask

    task automatic send_resp(input l15_resp_t r);
        l15_resp     = r;
        l15_resp_val = 1'b1;
        #1;
        if (!l15_resp_ack) event_error("response was not acknowledged");
        @(negedge clk);
        l15_resp_val = 1'b0;
    endtask

    task automatic run_op(input mem_op_t op, input word_t a, input word_t b, input word_t imm);
        addr_t     addr;
        int        nb;
        int        n;
        int        hold;
        l15_req_t  held;
        word_t     exp;
        addr = op[3] ? a + imm : a + b;
        nb   = width_bytes(op);
        @(negedge clk);
        mem_op = op;
        op_a   = a;
        op_b   = b;
        s_imm  = imm;
        n_ops++;
        if ((int'(addr[1:0]) % nb) != 0) begin
            n_mis++;
            wait_for(op[3] ? SEL_ST_MIS : SEL_LD_MIS, "misaligned flag", n);
            if (timed_out) return;
            if (ld_misaligned !== !op[3] || st_misaligned !== op[3])
                value_error($sformatf("op %b addr %h flags ld %b st %b",
                    op, addr, ld_misaligned, st_misaligned));
            repeat (10) begin
                @(negedge clk);
                if (l15_req_val) event_error("request raised for a misaligned access");
            end
        end else begin
            wait_for(SEL_REQ, "request", n);
            if (timed_out) return;
            if (!busy) event_error("busy low in the first request cycle");
            if (l15_req.rqtype !== (op[3] ? `STORE_RQ : `LOAD_RQ) || l15_req.address !== addr
                || l15_req.size !== msg_size(op[3] ? nb : 4))
                value_error($sformatf("request type %0d size %0d addr %h, op %b addr %h",
                    l15_req.rqtype, l15_req.size, l15_req.address, op, addr));
            if (op[3] && l15_req.data !== reverse_bytes(b))
                value_error($sformatf("store data %h for op_b %h", l15_req.data, b));
            held = l15_req;
            hold = rand_bits(2);
            repeat (hold) begin
                step_busy();
                if (!l15_req_val || l15_req !== held)
                    event_error("request changed while ack was withheld");
            end
            l15_ack        = 1'b1;
            l15_header_ack = 1'b1;
            step_busy();
            l15_ack        = 1'b0;
            l15_header_ack = 1'b0;
            if (l15_req_val) event_error("request still valid after it was accepted");
            if (op[3]) apply_store(held);
            repeat (rand_bits(2)) step_busy();
            if (rand_bits(2) == 0) begin   // wrong return type first
                n_inject++;
                send_resp(line_resp(addr, op[3] ? `LOAD_RET : `ST_ACK));
                if (done) event_error("done after an unmatched return type");
            end
            send_resp(line_resp(addr, op[3] ? `ST_ACK : `LOAD_RET));
            wait_for(SEL_DONE, "done", n);
            if (timed_out) return;
            if (n != 0) event_error("done not one cycle after the accepted response");
            if (!busy) event_error("busy low in the done cycle");
            exp = expect_load(op, addr);
            if (!op[3] && load_data !== exp)
                value_error($sformatf("op %b addr %h load_data %h, expected %h",
                    op, addr, load_data, exp));
        end
        mem_op = '0;    // bubble between accesses
    endtask

    initial begin : stimulus
        mem_op_t     op;
        logic [2:0]  pick;
        word_t       base;
        word_t       off;
        mem_op         = '0;
        op_a           = '0;
        op_b           = '0;
        s_imm          = '0;
        l15_resp       = '0;
        l15_resp_val   = 1'b0;
        l15_ack        = 1'b0;
        l15_header_ack = 1'b0;
        nrst           = 1'b0;
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = 8'(i * 29 + 17);   // odd step gives a unique byte per address
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        nrst = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        for (int k = 0; k < NUM_OPS && !timed_out; k++) begin
            pick = 3'(rand_bits(3));
            op   = OPS[pick];
            base = MEM_BASE + rand_bits(6);   // 64-byte window
            off  = rand_bits(5);
            if (op[3]) begin
                run_op(op, base, rand_bits(32), off);
            end else begin
                run_op(op, base, off, rand_bits(32));
            end
        end
        finish_run();
    end

endmodule

//--- src/mem_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage top: address generation, L1.5 request FSM
// and load extension
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_stage
    import core_mem_pkg::*, l15_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    // from execute
    input  mem_op_t    mem_op,
    input  word_t      op_a,
    input  word_t      op_b,
    input  word_t      s_imm,
    // L1.5 port
    output l15_req_t   l15_req,
    output logic       l15_req_val,
    input  l15_resp_t  l15_resp,
    input  logic       l15_resp_val,
    input  logic       l15_ack,
    input  logic       l15_header_ack,
    output logic       l15_resp_ack,
    // status and result
    output word_t      load_data,
    output logic       busy,
    output logic       done,
    output logic       ld_misaligned,
    output logic       st_misaligned
);

    mem_access_t  access;
    word_t        rdata;

    mem_addr_gen i_addr_gen (
        .clk    (clk),
        .nrst   (nrst),
        .mem_op (mem_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .s_imm  (s_imm),
        .access (access)
    );

    l15_req_fsm i_req_fsm (
        .clk            (clk),
        .nrst           (nrst),
        .access         (access),
        .l15_req        (l15_req),
        .l15_req_val    (l15_req_val),
        .l15_resp       (l15_resp),
        .l15_resp_val   (l15_resp_val),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .l15_resp_ack   (l15_resp_ack),
        .done           (done),
        .busy           (busy),
        .rdata          (rdata)
    );

    load_extend i_load_extend (
        .op        (access.op),
        .byte_off  (access.addr[1:0]),
        .rdata     (rdata),
        .load_data (load_data)
    );

    assign ld_misaligned = access.ld_misaligned;   // stage 6 levels
    assign st_misaligned = access.st_misaligned;

endmodule

//--- src/load_extend.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load data alignment with sign or zero extension
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module load_extend
    import core_mem_pkg::*;
(
    input  mem_op_t      op,
    input  logic [1:0]   byte_off,
    input  word_t        rdata,      // little-endian word from the line
    output word_t        load_data
);

    word_t  shifted;
    logic   sext_b;
    logic   sext_h;

    // move the addressed byte or half down to bit 0
    assign shifted = rdata >> {byte_off, 3'b000};
    assign sext_b  = op[0] & shifted[7];
    assign sext_h  = op[0] & shifted[15];

    always_comb begin
        load_data = '0;
        if (!op[3]) begin
            case (op[2:1])
                2'b10:   load_data = {{24{sext_b}}, shifted[7:0]};   // lb, lbu
                2'b01:   load_data = {{16{sext_h}}, shifted[15:0]};  // lh, lhu
                2'b11:   load_data = rdata;                          // lw
                default: load_data = '0;
            endcase
        end
    end

endmodule

//--- src/l15_req_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1.5 request FSM: issues one load or store per stage 6 access,
// waits for the matching return and selects the byte-swapped load word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mem_params.svh"

module l15_req_fsm
    import core_mem_pkg::*, l15_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    input  mem_access_t  access,
    output l15_req_t     l15_req,
    output logic         l15_req_val,
    input  l15_resp_t    l15_resp,
    input  logic         l15_resp_val,
    input  logic         l15_ack,
    input  logic         l15_header_ack,
    output logic         l15_resp_ack,
    output logic         done,
    output logic         busy,
    output word_t        rdata
);

    typedef enum logic [1:0] {s_req, s_wait, s_resp} state_t;

    state_t       state;
    l15_rqtype_t  rqtype_q;
    mem_access_t  last_acc;     // access of the request in flight or last served
    logic         served;       // last_acc already completed
    logic         aligned_op;
    logic         pending;
    logic         req_fire;
    logic         resp_fire;
    logic         ret_match;
    word_t        resp_word;

    function automatic word_t bswap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign aligned_op = access.op_valid && !access.ld_misaligned && !access.st_misaligned;
    // a served access is not reissued while stage 6 still shows it
    // so two identical back-to-back accesses need a bubble in between
    assign pending    = aligned_op && !(served && access == last_acc);

    assign l15_req_val  = (state == s_req) && pending;
    assign req_fire     = l15_req_val && l15_ack && l15_header_ack;
    assign resp_fire    = (state == s_wait) && l15_resp_val;
    assign l15_resp_ack = resp_fire;    // every response is taken whether it matches or not
    assign ret_match    = (rqtype_q == `STORE_RQ) ? (l15_resp.returntype == `ST_ACK)
                                                  : (l15_resp.returntype == `LOAD_RET);
    assign done         = (state == s_resp);
    assign busy         = pending;

    always_comb begin
        l15_req.rqtype  = access.rd ? `LOAD_RQ : `STORE_RQ;
        l15_req.address = access.addr;
        l15_req.data    = bswap(access.wdata);
        if (access.rd) begin
            l15_req.size = `MSG_SIZE_4B;
        end else begin
            case (access.byte_en)   // size from lane count
                4'b1111:                            l15_req.size = `MSG_SIZE_4B;
                4'b0011, 4'b1100:                   l15_req.size = `MSG_SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: l15_req.size = `MSG_SIZE_1B;
                default:                            l15_req.size = `MSG_SIZE_0B;
            endcase
        end
    end

    // address bits 3:2 pick the word out of the 16-byte line
    always_comb begin
        case (last_acc.addr[3:2])
            2'b00:   resp_word = l15_resp.data_0[63:32];
            2'b01:   resp_word = l15_resp.data_0[31:0];
            2'b10:   resp_word = l15_resp.data_1[63:32];
            default: resp_word = l15_resp.data_1[31:0];
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= s_req;
            rqtype_q <= '0;
            last_acc <= '0;
            served   <= 1'b0;
        end else begin
            case (state)
                s_req: begin
                    if (req_fire) begin
                        state    <= s_wait;
                        rqtype_q <= l15_req.rqtype;
                        last_acc <= access;
                    end
                end
                s_wait: begin
                    if (resp_fire && ret_match) state <= s_resp;  // mismatch is dropped
                end
                s_resp:  state <= s_req;
                default: state <= s_req;
            endcase

            if (state == s_resp)         served <= 1'b1;
            else if (access != last_acc) served <= 1'b0;
        end
    end

    // captured on the accepting edge so it is valid while done is high
    always_ff @(posedge clk) begin
        if (resp_fire && ret_match) rdata <= bswap(resp_word);
    end

    // execute holds its inputs, so the request cannot move under back-pressure
    a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
        l15_req_val && !(l15_ack && l15_header_ack) |=> l15_req_val && $stable(l15_req));

    // a served access raises no second request
    a_one_req: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !l15_req_val);

endmodule

//--- src/mem_addr_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 5 and stage 6 registers of the memory stage with address adder,
// misalignment detection and store byte enables
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_addr_gen
    import core_mem_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    input  mem_op_t      mem_op,
    input  word_t        op_a,     // base
    input  word_t        op_b,     // store source or I-immediate
    input  word_t        s_imm,
    output mem_access_t  access
);

    // stage 5
    mem_op_t      op5;
    word_t        op_a5;
    word_t        op_b5;
    word_t        s_imm5;

    addr_t        addr5;
    logic         is_store;
    logic         is_word;
    logic         mis5;
    byte_en_t     byte_en5;
    mem_access_t  acc5;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op5    <= '0;
            op_a5  <= '0;
            op_b5  <= '0;
            s_imm5 <= '0;
        end else begin
            op5    <= mem_op;
            op_a5  <= op_a;
            op_b5  <= op_b;
            s_imm5 <= s_imm;
        end
    end

    assign is_store = op5[3];
    assign is_word  = op5[2] & op5[1];
    assign addr5    = is_store ? (op_a5 + s_imm5) : (op_a5 + op_b5);

    // half or word on odd address, or word not on a 4-byte boundary
    assign mis5 = (op5[1] & addr5[0]) | (is_word & addr5[1]);

    always_comb begin
        byte_en5 = '0;
        if (is_store && !mis5) begin
            case (op5[2:1])
                2'b11:   byte_en5 = 4'b1111;
                2'b01:   byte_en5 = addr5[1] ? 4'b1100 : 4'b0011;
                2'b10:   byte_en5 = 4'b0001 << addr5[1:0];
                default: byte_en5 = '0;
            endcase
        end
    end

    always_comb begin
        acc5.op            = op5;
        acc5.addr          = addr5;
        acc5.wdata         = op_b5;
        acc5.byte_en       = byte_en5;
        acc5.op_valid      = |op5;
        acc5.rd            = (|op5) && !is_store && !mis5;
        acc5.ld_misaligned = mis5 && !is_store;
        acc5.st_misaligned = mis5 && is_store;
    end

    // stage 6
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) access <= '0;
        else       access <= acc5;
    end

    // a store always enables the lane at its address offset
    a_lane_at_addr: assert property (@(posedge clk) disable iff (!nrst)
        access.byte_en != '0 |-> access.byte_en[access.addr[1:0]]);

endmodule

//--- src/l15_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1.5 port types: request type, size, return type,
// request and response structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mem_params.svh"

package l15_pkg;

    typedef logic [`L15_RQTYPE_W-1:0]  l15_rqtype_t;
    typedef logic [`L15_SIZE_W-1:0]    l15_size_t;
    typedef logic [`L15_RETTYPE_W-1:0] l15_rettype_t;

    typedef struct packed {
        l15_rqtype_t  rqtype;
        l15_size_t    size;
        logic [31:0]  address;
        logic [31:0]  data;     // big endian byte order
    } l15_req_t;

    // data_0 holds bytes 0..7 of the line with byte 0 in the top bits
    typedef struct packed {
        l15_rettype_t              returntype;
        logic [`L15_DATA_W-1:0]    data_0;
        logic [`L15_DATA_W-1:0]    data_1;
    } l15_resp_t;

endpackage

//--- src/core_mem_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core side types: data word, byte address, memory op code,
// byte lane enables and the stage 6 access struct
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // op[3] store, op[2:1] width (11 word, 01 half, 10 byte), op[0] signed
    // 0000 is no memory op
    typedef logic [3:0] mem_op_t;

    // bit i enables byte i of the little-endian word
    typedef logic [3:0] byte_en_t;

    typedef struct packed {
        mem_op_t   op;
        addr_t     addr;           // full effective address
        word_t     wdata;          // store source, little endian
        byte_en_t  byte_en;        // zero for loads and misaligned
        logic      rd;             // aligned load
        logic      op_valid;       // any op bit set
        logic      ld_misaligned;
        logic      st_misaligned;
    } mem_access_t;

endpackage

//--- src/mem_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1.5 port field widths, request and return type codes
// and message size codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// field widths on the cache port
`define L15_RQTYPE_W    6
`define L15_SIZE_W      3
`define L15_RETTYPE_W   4
`define L15_DATA_W      64

// request types
`define LOAD_RQ         6'd0
`define STORE_RQ        6'd1

// return types
`define LOAD_RET        4'd0
`define ST_ACK          4'd4

// message sizes
`define MSG_SIZE_0B     3'd0
`define MSG_SIZE_1B     3'd1
`define MSG_SIZE_2B     3'd2
`define MSG_SIZE_4B     3'd3

`endif
